// ==== all.f ====
+incdir+.
design/cf_pixel_pkg.sv
design/cf_bus_pkg.sv
design/wb_if.sv
design/cam_byte_packer.sv
design/frame_writer.sv
design/frame_store.sv
design/display_reader.sv
design/cam_frame_top.sv
bench/cam_frame_props.sv
bench/tb_cam_frame.sv

// ==== Bender.yml ====
package:
  name: cam_frame

sources:
  - include_dirs:
      - .
    files:
      - design/cf_pixel_pkg.sv
      - design/cf_bus_pkg.sv
      - design/wb_if.sv
      - design/cam_byte_packer.sv
      - design/frame_writer.sv
      - design/frame_store.sv
      - design/display_reader.sv
      - design/cam_frame_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - bench/cam_frame_props.sv
      - bench/tb_cam_frame.sv

// ==== bench/tb_cam_frame.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cf_settings.svh"

module tb_cam_frame;

    localparam int TIMEOUT_CYC = 40;            // per-wait cycle limit

    logic                  core_clk;
    logic                  rst_n_i;
    logic                  cam_vsync_i;
    logic                  cam_href_i;
    logic [7:0]            cam_data_i;
    logic                  disp_req_i;
    logic [`CF_ADDR_W-1:0] disp_addr_i;
    logic                  disp_ready_o;
    logic                  disp_valid_o;
    logic [7:0]            disp_red_o;
    logic [7:0]            disp_green_o;
    logic [7:0]            disp_blue_o;
    logic [`CF_ADDR_W:0]   frame_pixels_o;

    cf_bus_pkg::wb_dat_t    store_model [`CF_FRAME_WORDS];  // mirrors the frame store
    cf_bus_pkg::wb_adr_t    model_adr;          // next write address, wraps
    cf_bus_pkg::pix_count_t model_cnt;          // whole pairs this frame
    cf_bus_pkg::pix_count_t model_last;         // pairs in the closed frame
    cf_bus_pkg::pix_count_t count1;             // frame 1 size, kept for readback
    integer                 seed;
    int                     err_cnt;
    int                     err_base;
    int                     test_cnt;
    int                     test_fail;

    always #2 core_clk = ~core_clk;             // 4 ns period

    cam_frame_top cam_frame_top_i (
        .core_clk       (core_clk),
        .rst_n_i        (rst_n_i),
        .cam_vsync_i    (cam_vsync_i),
        .cam_href_i     (cam_href_i),
        .cam_data_i     (cam_data_i),
        .disp_req_i     (disp_req_i),
        .disp_addr_i    (disp_addr_i),
        .disp_ready_o   (disp_ready_o),
        .disp_valid_o   (disp_valid_o),
        .disp_red_o     (disp_red_o),
        .disp_green_o   (disp_green_o),
        .disp_blue_o    (disp_blue_o),
        .frame_pixels_o (frame_pixels_o)
    );

    ////////////////////////////////////////////////////////////
    // expected values and compare tasks
    ////////////////////////////////////////////////////////////
    function automatic cf_pixel_pkg::rgb888_t widen_565(input cf_bus_pkg::wb_dat_t w);
        cf_pixel_pkg::rgb888_t c;
        c.red   = {w[15:11], 3'b000};           // fields shifted up, zero fill
        c.green = {w[10:5], 2'b00};
        c.blue  = {w[4:0], 3'b000};
        return c;
    endfunction

    task automatic check_color(input string name, input cf_pixel_pkg::rgb888_t exp,
                               input cf_pixel_pkg::rgb888_t act);
        if (act !== exp)
        begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input cf_bus_pkg::pix_count_t exp,
                               input cf_bus_pkg::pix_count_t act);
        if (act !== exp)
        begin
            $display("mismatch %s expected %0d actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("mismatch %s expected %b actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == err_base)
            $display("test %s: ok", name);
        else
        begin
            test_fail++;
            $display("test %s: %0d errors", name, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    ////////////////////////////////////////////////////////////
    // camera stimulus and model
    ////////////////////////////////////////////////////////////
    // one href burst, bytes paired within the burst only
    task automatic send_burst(input int len);
        logic [7:0] hi;
        logic [7:0] b;
        hi = '0;
        for (int i = 0; i < len; i++)
        begin
            b = $random(seed);
            @(posedge core_clk);
            cam_href_i <= 1'b1;
            cam_data_i <= b;
            if (i % 2 == 0)
                hi = b;                                 // first byte of a pair
            else
            begin
                store_model[model_adr] = {hi, b};       // high byte first
                model_adr++;
                if (model_cnt != `CF_FRAME_WORDS)
                    model_cnt++;                        // saturates like the writer
            end
        end
        @(posedge core_clk);
        cam_href_i <= 1'b0;                             // odd trailing byte dropped here
        cam_data_i <= $random(seed);                    // junk outside href
        repeat ($unsigned($random(seed)) % 3)
            @(posedge core_clk);
    endtask

    // writer takes one pixel per 3 cycles, so a burst holds at most one pair
    task automatic send_frame(input int target);
        while (model_cnt < target)
            send_burst(1 + $unsigned($random(seed)) % 3);
        repeat (6) @(posedge core_clk);                 // last write drains
    endtask

    task automatic vsync_pulse();
        @(posedge core_clk);
        cam_vsync_i <= 1'b1;
        repeat (3) @(posedge core_clk);
        cam_vsync_i <= 1'b0;
        repeat (4) @(posedge core_clk);                 // frame start seen by now
        model_last = model_cnt;
        model_cnt  = '0;
        model_adr  = '0;
    endtask

    ////////////////////////////////////////////////////////////
    // display reads
    ////////////////////////////////////////////////////////////
    task automatic read_and_check(input cf_bus_pkg::wb_adr_t adr, input string name);
        int                    wait_cyc;
        int                    lat;
        cf_pixel_pkg::rgb888_t got;
        wait_cyc = 0;
        @(negedge core_clk);
        while (!disp_ready_o && wait_cyc < TIMEOUT_CYC)
        begin
            @(negedge core_clk);
            wait_cyc++;
        end
        if (!disp_ready_o)
        begin
            $display("%s: timeout, disp_ready_o never went high", name);
            err_cnt++;
        end
        else
        begin
            @(posedge core_clk);
            disp_req_i  <= 1'b1;
            disp_addr_i <= adr;
            @(posedge core_clk);                        // accepting edge
            disp_req_i  <= 1'b0;
            lat = 0;
            @(negedge core_clk);
            while (!disp_valid_o && lat < TIMEOUT_CYC)
            begin
                check_flag({name, "_busy"}, 1'b0, disp_ready_o);
                @(negedge core_clk);
                lat++;
            end
            if (!disp_valid_o)
            begin
                $display("%s: timeout, disp_valid_o never pulsed", name);
                err_cnt++;
            end
            else
            begin
                if (lat != 3)
                begin
                    $display("mismatch %s_latency expected 3 actual %0d", name, lat);
                    err_cnt++;
                end
                got = {disp_red_o, disp_green_o, disp_blue_o};
                check_color(name, widen_565(store_model[adr]), got);
                check_flag({name, "_ready"}, 1'b1, disp_ready_o);
                @(negedge core_clk);
                check_flag({name, "_one_pulse"}, 1'b0, disp_valid_o);
            end
        end
    endtask

    task automatic readback(input string name, input cf_bus_pkg::pix_count_t n);
        for (int a = 0; a < n; a++)
            read_and_check(cf_bus_pkg::wb_adr_t'(a), $sformatf("%s[%0d]", name, a));
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        core_clk    = 1'b0;
        rst_n_i     = 1'b0;
        cam_vsync_i = 1'b0;
        cam_href_i  = 1'b0;
        cam_data_i  = '0;
        disp_req_i  = 1'b0;
        disp_addr_i = '0;
        seed        = 64;
        err_cnt     = 0;
        err_base    = 0;
        test_cnt    = 0;
        test_fail   = 0;
        model_adr   = '0;
        model_cnt   = '0;
        model_last  = '0;

        repeat (5) @(posedge core_clk);
        rst_n_i <= 1'b1;
        @(negedge core_clk);
        check_flag("reset_valid", 1'b0, disp_valid_o);
        check_flag("reset_ready", 1'b1, disp_ready_o);
        check_count("reset_count", '0, frame_pixels_o);
        end_test("reset_state");

        vsync_pulse();                                  // opens frame 1
        send_frame(20 + $unsigned($random(seed)) % 12);
        vsync_pulse();                                  // closes frame 1
        check_count("frame1_count", model_last, frame_pixels_o);
        end_test("frame1_count");
        count1 = model_last;
        readback("frame1_readback", count1);
        end_test("frame1_readback");

        send_frame(4 + $unsigned($random(seed)) % 8);   // shorter frame
        vsync_pulse();
        check_count("frame2_count", model_last, frame_pixels_o);
        end_test("frame2_count");
        readback("frame2_readback", count1);            // tail still holds frame 1
        end_test("frame2_readback");

        $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cam_frame_props.sv ====
`timescale 1ns/1ps
`default_nettype none

// wishbone classic rules on both frame_store ports
module cam_frame_props (
    input logic core_clk,
    input logic rst_n_i,
    input logic wr_cyc_i,
    input logic wr_stb_i,
    input logic wr_ack_i,
    input logic rd_cyc_i,
    input logic rd_stb_i,
    input logic rd_ack_i
);

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////
    wr_ack_needs_req: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        wr_ack_i |-> (wr_cyc_i && wr_stb_i))
        else $error("write port ack without cyc and stb");

    wr_stb_held: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        (wr_stb_i && !wr_ack_i) |=> wr_stb_i)       // no abort before ack
        else $error("write port stb dropped before ack");

    wr_ack_single: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        wr_ack_i |=> !wr_ack_i)
        else $error("write port ack held for two cycles");

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////
    rd_ack_needs_req: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        rd_ack_i |-> (rd_cyc_i && rd_stb_i))
        else $error("read port ack without cyc and stb");

    rd_stb_held: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        (rd_stb_i && !rd_ack_i) |=> rd_stb_i)
        else $error("read port stb dropped before ack");

    rd_ack_single: assert property (@(posedge core_clk) disable iff (!rst_n_i)
        rd_ack_i |=> !rd_ack_i)
        else $error("read port ack held for two cycles");

endmodule

// names resolve inside frame_store
bind frame_store cam_frame_props cam_frame_props_i (
    .core_clk (core_clk),
    .rst_n_i  (rst_n_i),
    .wr_cyc_i (wb_wr.cyc),
    .wr_stb_i (wb_wr.stb),
    .wr_ack_i (wb_wr.ack),
    .rd_cyc_i (wb_rd.cyc),
    .rd_stb_i (wb_rd.stb),
    .rd_ack_i (wb_rd.ack)
);

`default_nettype wire

// ==== design/cam_frame_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cf_settings.svh"

module cam_frame_top (
    input  logic                  core_clk,
    input  logic                  rst_n_i,
    input  logic                  cam_vsync_i,
    input  logic                  cam_href_i,
    input  logic [7:0]            cam_data_i,
    input  logic                  disp_req_i,
    input  logic [`CF_ADDR_W-1:0] disp_addr_i,
    output logic                  disp_ready_o,
    output logic                  disp_valid_o,
    output logic [7:0]            disp_red_o,
    output logic [7:0]            disp_green_o,
    output logic [7:0]            disp_blue_o,
    output logic [`CF_ADDR_W:0]   frame_pixels_o   // pixel count of the last frame
);

    logic                     pix_valid;
    cf_pixel_pkg::cam_pixel_t pix;
    logic                     frame_start;
    cf_pixel_pkg::rgb888_t    disp_color;

    wb_if wb_wr ();     // writer to store
    wb_if wb_rd ();     // reader to store

    ////////////////////////////////////////////////////////////
    // capture side
    ////////////////////////////////////////////////////////////
    cam_byte_packer cam_byte_packer_i (
        .core_clk      (core_clk),
        .rst_n_i       (rst_n_i),
        .cam_vsync_i   (cam_vsync_i),
        .cam_href_i    (cam_href_i),
        .cam_data_i    (cam_data_i),
        .pix_valid_o   (pix_valid),
        .pix_o         (pix),
        .frame_start_o (frame_start)
    );

    frame_writer frame_writer_i (
        .core_clk       (core_clk),
        .rst_n_i        (rst_n_i),
        .pix_valid_i    (pix_valid),
        .pix_i          (pix),
        .frame_start_i  (frame_start),
        .wb_wr          (wb_wr.master),
        .frame_pixels_o (frame_pixels_o)
    );

    frame_store frame_store_i (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .wb_wr    (wb_wr.slave),
        .wb_rd    (wb_rd.slave)
    );

    ////////////////////////////////////////////////////////////
    // display side
    ////////////////////////////////////////////////////////////
    display_reader display_reader_i (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n_i),
        .disp_req_i   (disp_req_i),
        .disp_addr_i  (disp_addr_i),
        .wb_rd        (wb_rd.master),
        .disp_ready_o (disp_ready_o),
        .disp_valid_o (disp_valid_o),
        .disp_color_o (disp_color)
    );

    assign disp_red_o   = disp_color.red;
    assign disp_green_o = disp_color.green;
    assign disp_blue_o  = disp_color.blue;

endmodule

`default_nettype wire

// ==== design/display_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cf_settings.svh"

module display_reader (
    input  logic                    core_clk,
    input  logic                    rst_n_i,
    input  logic                    disp_req_i,    // fetch one pixel
    input  cf_bus_pkg::wb_adr_t     disp_addr_i,
    wb_if.master                    wb_rd,         // to frame_store
    output logic                    disp_ready_o,  // idle, can accept
    output logic                    disp_valid_o,  // colour updated this cycle
    output cf_pixel_pkg::rgb888_t   disp_color_o
);

    cf_pixel_pkg::cam_pixel_t rd_word;      // returned word
    logic                     rd_pend;      // word captured, widen next
    logic                     accept;

    assign wb_rd.we    = 1'b0;              // read-only master
    assign wb_rd.dat_w = '0;
    assign accept      = disp_req_i & disp_ready_o;

    ////////////////////////////////////////////////////////////
    // request / bus control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            wb_rd.cyc    <= 1'b0;
            wb_rd.stb    <= 1'b0;
            rd_pend      <= 1'b0;
            disp_ready_o <= 1'b1;
            disp_valid_o <= 1'b0;
        end
        else
        begin
            rd_pend      <= wb_rd.ack;      // ack lasts one cycle
            disp_valid_o <= rd_pend;        // 3 cycles after accept
            if (accept)
            begin
                wb_rd.cyc    <= 1'b1;
                wb_rd.stb    <= 1'b1;
                disp_ready_o <= 1'b0;       // busy until valid
            end
            else if (wb_rd.ack)
            begin
                wb_rd.cyc <= 1'b0;
                wb_rd.stb <= 1'b0;
            end
            if (rd_pend)
                disp_ready_o <= 1'b1;       // ready again with valid
        end
    end

    // payload path, colour holds until the next result
    always_ff @(posedge core_clk)
    begin
        if (accept)
            wb_rd.adr <= disp_addr_i;
        if (wb_rd.ack)
            rd_word <= wb_rd.dat_r;
        if (rd_pend)
        begin
            disp_color_o.red   <= {rd_word.color.red,   3'b000};   // zero low bits
            disp_color_o.green <= {rd_word.color.green, 2'b00};
            disp_color_o.blue  <= {rd_word.color.blue,  3'b000};
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cf_settings.svh"

module frame_store (
    input  logic core_clk,
    input  logic rst_n_i,
    wb_if.slave  wb_wr,     // camera side, writes
    wb_if.slave  wb_rd      // display side, reads
);

    cf_bus_pkg::wb_dat_t mem [`CF_FRAME_WORDS];    // pixel memory

    logic wr_hit;           // first cycle of a write port access
    logic rd_hit;           // first cycle of a read port access

    assign wr_hit = wb_wr.cyc & wb_wr.stb & ~wb_wr.ack;
    assign rd_hit = wb_rd.cyc & wb_rd.stb & ~wb_rd.ack;

    assign wb_wr.dat_r = '0;                    // write port returns no data

    ////////////////////////////////////////////////////////////
    // memory array
    ////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (wr_hit && wb_wr.we)
            mem[wb_wr.adr] <= wb_wr.dat_w;
        if (rd_hit && !wb_rd.we)
            wb_rd.dat_r <= mem[wb_rd.adr];      // pre-write contents on a collision
    end

    ////////////////////////////////////////////////////////////
    // acks, one cycle after cyc and stb, never two in a row
    ////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            wb_wr.ack <= 1'b0;
            wb_rd.ack <= 1'b0;
        end
        else
        begin
            wb_wr.ack <= wr_hit;
            wb_rd.ack <= rd_hit;
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cf_settings.svh"

module frame_writer (
    input  logic                     core_clk,
    input  logic                     rst_n_i,
    input  logic                     pix_valid_i,    // from the packer
    input  cf_pixel_pkg::cam_pixel_t pix_i,
    input  logic                     frame_start_i,
    wb_if.master                     wb_wr,          // to frame_store
    output cf_bus_pkg::pix_count_t   frame_pixels_o  // pixels in the last frame
);

    cf_bus_pkg::wb_adr_t    next_adr;       // address of the next write
    cf_bus_pkg::pix_count_t pix_cnt;        // acked writes this frame
    cf_bus_pkg::pix_count_t pix_cnt_inc;    // count including this cycle's ack
    logic                   start_wr;       // new pixel, bus idle

    assign wb_wr.we = 1'b1;                 // write-only master
    assign start_wr = pix_valid_i & ~wb_wr.cyc;

    // saturate at a full store, address keeps wrapping
    always_comb
    begin
        pix_cnt_inc = pix_cnt;
        if (wb_wr.ack && (pix_cnt != cf_bus_pkg::pix_count_t'(`CF_FRAME_WORDS)))
            pix_cnt_inc = pix_cnt + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // wishbone handshake
    ////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            wb_wr.cyc <= 1'b0;
            wb_wr.stb <= 1'b0;
        end
        else if (wb_wr.ack)
        begin
            wb_wr.cyc <= 1'b0;              // done at the ack edge
            wb_wr.stb <= 1'b0;
        end
        else if (start_wr)
        begin
            wb_wr.cyc <= 1'b1;              // stb one cycle after pix_valid
            wb_wr.stb <= 1'b1;
        end
    end

    // holding register, stays put until ack
    always_ff @(posedge core_clk)
    begin
        if (start_wr)
        begin
            wb_wr.adr   <= next_adr;
            wb_wr.dat_w <= pix_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // address and per-frame count
    ////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            next_adr       <= '0;
            pix_cnt        <= '0;
            frame_pixels_o <= '0;
        end
        else if (frame_start_i)
        begin
            frame_pixels_o <= pix_cnt_inc;  // close out previous frame
            pix_cnt        <= '0;
            next_adr       <= '0;           // new frame from address 0
        end
        else
        begin
            pix_cnt <= pix_cnt_inc;
            if (wb_wr.ack)
                next_adr <= next_adr + 1'b1;    // wraps past the store size
        end
    end

endmodule

`default_nettype wire

// ==== design/cam_byte_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cf_settings.svh"

module cam_byte_packer (
    input  logic                     core_clk,
    input  logic                     rst_n_i,
    input  logic                     cam_vsync_i,   // frame strobe
    input  logic                     cam_href_i,    // line strobe, data valid
    input  logic [`CF_PIX_W/2-1:0]   cam_data_i,    // camera byte
    output logic                     pix_valid_o,   // one-cycle pixel pulse
    output cf_pixel_pkg::cam_pixel_t pix_o,
    output logic                     frame_start_o  // vsync rising edge
);

    logic [`CF_PIX_W/2-1:0] data_d;     // registered camera byte
    logic [`CF_PIX_W/2-1:0] hi_q;       // held first byte
    logic                   href_d;
    logic                   vsync_d;
    logic                   vsync_dd;   // for edge detect
    logic                   phase;      // 1 = next byte is the low byte

    ////////////////////////////////////////////////////////////
    // input registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        data_d <= cam_data_i;                    // payload, no reset
    end

    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            href_d        <= 1'b0;
            vsync_d       <= 1'b0;
            vsync_dd      <= 1'b0;
            phase         <= 1'b0;
            pix_valid_o   <= 1'b0;
            frame_start_o <= 1'b0;
        end
        else
        begin
            href_d        <= cam_href_i;
            vsync_d       <= cam_vsync_i;
            vsync_dd      <= vsync_d;
            frame_start_o <= vsync_d & ~vsync_dd;       // rise of registered vsync
            phase         <= href_d & ~phase;           // clears outside href, drops odd byte
            pix_valid_o   <= href_d & phase;            // second byte of a pair
        end
    end

    ////////////////////////////////////////////////////////////
    // byte pairing, high byte first
    ////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (href_d && !phase)
            hi_q <= data_d;                             // first byte waits
        if (href_d && phase)
        begin
            pix_o.capture.hi_byte <= hi_q;
            pix_o.capture.lo_byte <= data_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cf_settings.svh"

// wishbone classic, single transfers only
interface wb_if;

    logic                cyc;        // cycle in progress
    logic                stb;        // strobe, valid transfer
    logic                we;         // 1 write, 0 read
    cf_bus_pkg::wb_adr_t adr;        // word address
    cf_bus_pkg::wb_dat_t dat_w;      // master to slave data
    cf_bus_pkg::wb_dat_t dat_r;      // slave to master data
    logic                ack;        // single-cycle termination

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// ==== design/cf_bus_pkg.sv ====
`default_nettype none

`include "cf_settings.svh"

package cf_bus_pkg;

    // wishbone address into the frame store, wraps at CF_FRAME_WORDS
    typedef logic [`CF_ADDR_W-1:0] wb_adr_t;

    typedef logic [`CF_PIX_W-1:0]  wb_dat_t;     // one stored pixel

    // one extra bit so a full frame count fits
    typedef logic [`CF_ADDR_W:0]   pix_count_t;

endpackage

`default_nettype wire

// ==== design/cf_pixel_pkg.sv ====
`default_nettype none

`include "cf_settings.svh"

package cf_pixel_pkg;

    // two camera bytes, high byte first on the wire
    typedef struct packed {
        logic [`CF_PIX_W/2-1:0] hi_byte;     // first byte of the pair
        logic [`CF_PIX_W/2-1:0] lo_byte;     // second byte
    } cam_bytes_t;

    typedef struct packed {
        logic [4:0] red;                     // bits 15:11
        logic [5:0] green;                   // bits 10:5
        logic [4:0] blue;                    // bits 4:0
    } rgb565_t;

    // same 16-bit word, capture view and colour view
    typedef union packed {
        cam_bytes_t capture;                 // written by the packer
        rgb565_t    color;                   // decoded by the reader
    } cam_pixel_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;                              // display colour

endpackage

`default_nettype wire

// ==== cf_settings.svh ====
`ifndef CF_SETTINGS_SVH
`define CF_SETTINGS_SVH

////////////////////////////////////////////////////////////
// frame store geometry
////////////////////////////////////////////////////////////
`define CF_FRAME_WORDS 64   // pixels held in the store
`define CF_ADDR_W      6    // store address bits
`define CF_PIX_W       16   // rgb565 word

`endif
